/* design/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // ============================================================
    // Line configuration
    // ============================================================

    // Parity mode as driven on parity_sel
    typedef enum logic [1:0] {
        PARITY_NONE = 2'b00,
        PARITY_EVEN = 2'b01,
        PARITY_ODD  = 2'b10,
        PARITY_RSVD = 2'b11     // Treated as none
    } parity_e;

    // Baud selection as driven on baud_sel
    typedef enum logic [1:0] {
        BAUD_9600   = 2'b00,
        BAUD_19200  = 2'b01,
        BAUD_38400  = 2'b10,
        BAUD_115200 = 2'b11
    } baud_e;

    // ============================================================
    // Engine states
    // ============================================================
    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_e;

    // Baud ticks per serial bit
    localparam int OVERSAMPLE = 16;

    // Receive FIFO entry, flags above the byte
    typedef struct packed {
        logic       frame_err;  // Stop bit sampled low
        logic       parity_err; // Parity bit mismatch
        logic [7:0] data;
    } rx_entry_t;

    localparam int RX_ENTRY_W = $bits(rx_entry_t); // 10 bits

endpackage

`default_nettype wire

/* design/uart_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One FIFO, one writer, one reader
interface uart_fifo_if #(
    parameter int DATA_WIDTH = 8
);
    logic                  push;   // Ignored while full
    logic [DATA_WIDTH-1:0] wdata;
    logic                  full;
    logic                  pop;    // Ignored while empty
    logic [DATA_WIDTH-1:0] rdata;  // Oldest entry, no latency
    logic                  empty;

    modport writer (output push, output wdata, input full);
    modport reader (output pop, input rdata, input empty);

    // Storage side
    modport store (
        input  push, input  wdata, input  pop,
        output full, output rdata, output empty
    );
endinterface

`default_nettype wire

/* design/uart_baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen #(
    parameter int CLK_FREQ = 18_432_000
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire uart_pkg::baud_e baud_sel,
    output logic                baud_tick
);

    // Clocks per oversample tick, fixed at elaboration
    localparam int DIV_9600   = CLK_FREQ / (uart_pkg::OVERSAMPLE * 9600);
    localparam int DIV_19200  = CLK_FREQ / (uart_pkg::OVERSAMPLE * 19200);
    localparam int DIV_38400  = CLK_FREQ / (uart_pkg::OVERSAMPLE * 38400);
    localparam int DIV_115200 = CLK_FREQ / (uart_pkg::OVERSAMPLE * 115200);
    localparam int CNT_W      = $clog2(DIV_9600 + 1);   // Slowest rate sets width

    logic [CNT_W-1:0] reload;   // Divisor minus one
    logic [CNT_W-1:0] cnt;
    uart_pkg::baud_e  sel_q;    // Last seen selection

    always_comb begin
        case (baud_sel)
            uart_pkg::BAUD_9600:  reload = CNT_W'(DIV_9600 - 1);
            uart_pkg::BAUD_19200: reload = CNT_W'(DIV_19200 - 1);
            uart_pkg::BAUD_38400: reload = CNT_W'(DIV_38400 - 1);
            default:              reload = CNT_W'(DIV_115200 - 1);
        endcase
    end

    // Down counter, tick on wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q     <= uart_pkg::BAUD_9600;
            cnt       <= CNT_W'(DIV_9600 - 1);
            baud_tick <= 1'b0;
        end else begin
            sel_q <= baud_sel;
            if (baud_sel != sel_q) begin
                cnt       <= reload;        // Restart, full first period
                baud_tick <= 1'b0;
            end else if (cnt == '0) begin
                cnt       <= reload;
                baud_tick <= 1'b1;
            end else begin
                cnt       <= cnt - 1'b1;
                baud_tick <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/uart_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 16
) (
    input  wire         clk,
    input  wire         rst_n,
    uart_fifo_if.store  port
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [ADDR_W-1:0]     wr_ptr;
    logic [ADDR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]      count;      // Occupancy
    logic                  do_push;
    logic                  do_pop;

    // Pointer step with wrap for any depth
    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] p);
        return (p == ADDR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = port.push && !port.full;   // Drop when full
    assign do_pop  = port.pop && !port.empty;   // Drop when empty

    // Flags straight from the count
    assign port.full  = (count == CNT_W'(DEPTH));
    assign port.empty = (count == '0);
    assign port.rdata = mem[rd_ptr];            // Head always visible

    // ============================================================
    // Storage
    // ============================================================
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= port.wdata;
        end
    end

    // ============================================================
    // Pointers and count
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   baud_tick,
    input  wire uart_pkg::parity_e parity,
    uart_fifo_if.reader           fifo,
    output logic                  txd,
    output logic                  busy,
    output logic                  done
);

    localparam int TICK_W = $clog2(uart_pkg::OVERSAMPLE);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(uart_pkg::OVERSAMPLE - 1);

    uart_pkg::tx_state_e state;
    logic [TICK_W-1:0]   tick_cnt;   // Ticks into current bit
    logic [2:0]          bit_idx;    // Data bit on the line
    logic [7:0]          shreg;      // Current bit at [0]
    logic                par_acc;    // Running parity
    uart_pkg::parity_e   mode_q;     // Mode held for the frame
    logic                bit_end;
    logic                has_parity;

    assign bit_end    = baud_tick && (tick_cnt == LAST_TICK);
    assign has_parity = (mode_q == uart_pkg::PARITY_EVEN) || (mode_q == uart_pkg::PARITY_ODD);

    // Start only on a tick so every bit is 16 whole ticks
    assign fifo.pop = (state == uart_pkg::TX_IDLE) && baud_tick && !fifo.empty;
    assign busy     = (state != uart_pkg::TX_IDLE);

    // ============================================================
    // Frame sequencing
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= uart_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;               // Line idles high
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (baud_tick && state != uart_pkg::TX_IDLE) begin
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            end
            case (state)
                uart_pkg::TX_IDLE: if (fifo.pop) begin
                    state    <= uart_pkg::TX_START;
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    txd      <= 1'b0;       // Start bit
                end
                uart_pkg::TX_START: if (bit_end) begin
                    state <= uart_pkg::TX_DATA;
                    txd   <= shreg[0];      // LSB first
                end
                uart_pkg::TX_DATA: if (bit_end) begin
                    if (bit_idx == 3'd7) begin
                        if (has_parity) begin
                            state <= uart_pkg::TX_PARITY;
                            txd   <= par_acc ^ shreg[0];
                        end else begin
                            state <= uart_pkg::TX_STOP;
                            txd   <= 1'b1;
                        end
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        txd     <= shreg[1];    // Next bit before shift lands
                    end
                end
                uart_pkg::TX_PARITY: if (bit_end) begin
                    state <= uart_pkg::TX_STOP;
                    txd   <= 1'b1;
                end
                uart_pkg::TX_STOP: if (bit_end) begin
                    state <= uart_pkg::TX_IDLE;
                    done  <= 1'b1;          // End of stop bit
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Byte, mode and parity
    always_ff @(posedge clk) begin
        if (fifo.pop) begin
            shreg   <= fifo.rdata;
            mode_q  <= parity;
            par_acc <= (parity == uart_pkg::PARITY_ODD); // Odd starts at one
        end else if (state == uart_pkg::TX_DATA && bit_end) begin
            par_acc <= par_acc ^ shreg[0];
            shreg   <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   baud_tick,
    input  wire                   rxd,
    input  wire uart_pkg::parity_e parity,
    uart_fifo_if.writer           fifo,
    output logic                  overrun
);

    localparam int TICK_W = $clog2(uart_pkg::OVERSAMPLE);
    localparam logic [TICK_W-1:0] HALF_TICK = TICK_W'(uart_pkg::OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(uart_pkg::OVERSAMPLE - 1);

    uart_pkg::rx_state_e state;
    logic [TICK_W-1:0]   tick_cnt;
    logic [2:0]          bit_idx;
    logic                rxd_meta;   // First synchroniser stage
    logic                rxd_sync;   // Safe to use
    logic                rxd_prev;   // For edge detect
    logic [7:0]          shreg;
    logic                perr;
    uart_pkg::parity_e   mode_q;
    logic                start_mid;  // Middle of start bit
    logic                sample;     // Middle of a later bit
    logic                stop_sample;
    logic                has_parity;
    uart_pkg::rx_entry_t entry;

    assign start_mid   = baud_tick && (tick_cnt == HALF_TICK);
    assign sample      = baud_tick && (tick_cnt == LAST_TICK);
    assign stop_sample = (state == uart_pkg::RX_STOP) && sample;
    assign has_parity  = (mode_q == uart_pkg::PARITY_EVEN) || (mode_q == uart_pkg::PARITY_ODD);

    // Entry goes out at mid stop bit
    assign entry.data       = shreg;
    assign entry.parity_err = perr;
    assign entry.frame_err  = !rxd_sync;
    assign fifo.wdata       = entry;
    assign fifo.push        = stop_sample && !fifo.full;

    // ============================================================
    // Input synchroniser
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // ============================================================
    // Frame sequencing
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= uart_pkg::RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            overrun  <= 1'b0;
        end else begin
            overrun <= stop_sample && fifo.full;    // Frame dropped
            if (baud_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                uart_pkg::RX_IDLE: if (rxd_prev && !rxd_sync) begin
                    state    <= uart_pkg::RX_START; // Falling edge only
                    tick_cnt <= '0;
                end
                uart_pkg::RX_START: if (start_mid) begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    state    <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA; // Glitch
                end
                uart_pkg::RX_DATA: if (sample) begin
                    if (bit_idx == 3'd7) begin
                        state <= has_parity ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                uart_pkg::RX_PARITY: if (sample) state <= uart_pkg::RX_STOP;
                uart_pkg::RX_STOP:   if (sample) state <= uart_pkg::RX_IDLE;
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // Samples, mode and parity check
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_IDLE) begin
            mode_q <= parity;
            perr   <= 1'b0;
        end
        if (state == uart_pkg::RX_DATA && sample) begin
            shreg <= {rxd_sync, shreg[7:1]};    // LSB arrives first
        end
        if (state == uart_pkg::RX_PARITY && sample) begin
            perr <= rxd_sync != ((^shreg) ^ (mode_q == uart_pkg::PARITY_ODD));
        end
    end

endmodule

`default_nettype wire

/* design/uart_core.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_core #(
    parameter int CLK_FREQ   = 18_432_000,
    parameter int FIFO_DEPTH = 16
) (
    input  wire        clk,
    input  wire        rst_n,
    // Host transmit side
    input  wire  [7:0] tx_data,
    input  wire        tx_en,
    output logic       tx_full,
    output logic       txd,
    output logic       tx_busy,
    output logic       tx_done,
    // Host receive side
    input  wire        rxd,
    output logic [7:0] rx_data,
    output logic       rx_error,
    output logic       rx_ready,
    input  wire        rx_rd,
    output logic       rx_overrun,
    // Line setup
    input  wire  [1:0] parity_sel,
    input  wire  [1:0] baud_sel
);

    uart_pkg::parity_e   parity;
    uart_pkg::baud_e     baud;
    logic                baud_tick;
    uart_pkg::rx_entry_t rx_head;

    assign parity = uart_pkg::parity_e'(parity_sel);
    assign baud   = uart_pkg::baud_e'(baud_sel);

    uart_fifo_if #(.DATA_WIDTH(8))                   tx_q ();
    uart_fifo_if #(.DATA_WIDTH(uart_pkg::RX_ENTRY_W)) rx_q ();

    // ============================================================
    // Host strobes
    // ============================================================
    assign tx_q.push  = tx_en;
    assign tx_q.wdata = tx_data;
    assign tx_full    = tx_q.full;

    assign rx_q.pop = rx_rd;
    assign rx_head  = rx_q.rdata;
    assign rx_ready = !rx_q.empty;
    assign rx_data  = rx_head.data;
    assign rx_error = rx_ready && (rx_head.parity_err || rx_head.frame_err); // Valid head only

    // ============================================================
    // Blocks
    // ============================================================
    uart_baud_gen #(.CLK_FREQ(CLK_FREQ)) u_baud (
        .clk, .rst_n, .baud_sel(baud), .baud_tick
    );

    uart_fifo #(.DATA_WIDTH(8), .DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk, .rst_n, .port(tx_q)
    );

    uart_fifo #(.DATA_WIDTH(uart_pkg::RX_ENTRY_W), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk, .rst_n, .port(rx_q)
    );

    uart_tx u_tx (
        .clk, .rst_n, .baud_tick, .parity, .fifo(tx_q),
        .txd, .busy(tx_busy), .done(tx_done)
    );

    uart_rx u_rx (
        .clk, .rst_n, .baud_tick, .rxd, .parity, .fifo(rx_q),
        .overrun(rx_overrun)
    );

endmodule

`default_nettype wire

/* test/uart_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_core_props (
    input wire clk,
    input wire rst_n,
    input wire tx_done,
    input wire txd,
    input wire tx_busy,
    input wire rx_ready,
    input wire rx_push    // Accepted receive FIFO push
);

    // ============================================================
    // Transmit side
    // ============================================================
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done |=> !tx_done)
        else $error("tx_done lasted more than one clock");

    a_line_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> txd)
        else $error("txd low while the transmitter is idle");

    // ============================================================
    // Receive side
    // ============================================================
    a_ready_push: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rx_ready) |-> $past(rx_push))
        else $error("rx_ready rose with no push before it");

endmodule

bind uart_core uart_core_props u_props (
    .clk, .rst_n, .tx_done, .txd, .tx_busy,
    .rx_ready,
    .rx_push(rx_q.push)
);

`default_nettype wire

/* test/uart_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_core_tb;

    localparam int CLK_FREQ   = 18_432_000;
    localparam int FIFO_DEPTH = 16;
    localparam int DIV_FAST   = CLK_FREQ / (16 * 115200);   // Clocks per tick
    localparam int DIV_SLOW   = CLK_FREQ / (16 * 9600);

    logic       clk;
    logic       rst_n;
    logic [7:0] tx_data;
    logic       tx_en;
    logic       tx_full;
    logic       txd;
    logic       tx_busy;
    logic       tx_done;
    logic       rxd;
    logic [7:0] rx_data;
    logic       rx_error;
    logic       rx_ready;
    logic       rx_rd;
    logic       rx_overrun;
    logic [1:0] parity_sel;
    logic [1:0] baud_sel;

    logic [31:0] seed;
    int          bit_clks;      // Serial bit length in clocks
    int          done_cnt = 0;  // tx_done pulses seen
    int          ovr_cnt  = 0;  // rx_overrun pulses seen

    uart_core #(.CLK_FREQ(CLK_FREQ), .FIFO_DEPTH(FIFO_DEPTH)) uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (tx_done) done_cnt <= done_cnt + 1;
        if (rx_overrun) ovr_cnt <= ovr_cnt + 1;
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [7:0] next_byte();
        seed = xorshift32(seed);
        return seed[7:0];
    endfunction

    function automatic logic has_parity(input logic [1:0] mode);
        return (mode == uart_pkg::PARITY_EVEN) || (mode == uart_pkg::PARITY_ODD);
    endfunction

    // Even mode gives an even count of ones over data and parity
    function automatic logic parity_of(input logic [7:0] d, input logic [1:0] mode);
        return (mode == uart_pkg::PARITY_ODD) ? ~^d : ^d;
    endfunction

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out while waiting for %s", what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic next_edge();     // Drive and sample point
        @(posedge clk);
        #2;
    endtask

    task automatic push_byte(input logic [7:0] b);
        tx_data = b;
        tx_en   = 1'b1;
        next_edge();
        tx_en   = 1'b0;
    endtask

    // ============================================================
    // Serial line model
    // ============================================================
    task automatic drive_bit(input logic v);
        rxd = v;
        repeat (bit_clks) next_edge();
    endtask

    task automatic send_frame(input logic [7:0] b, input logic bad_par, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);                        // LSB first
        end
        if (has_parity(parity_sel)) drive_bit(parity_of(b, parity_sel) ^ bad_par);
        drive_bit(stop_bit);
        drive_bit(1'b1);                            // Idle gap
    endtask

    task automatic wait_line_low();
        int n;
        n = 0;
        while (txd !== 1'b0) begin
            if (n == 64 * bit_clks) timeout_fail("a start bit on txd");
            n++;
            next_edge();
        end
    endtask

    // Decode one frame from txd at mid-bit
    task automatic expect_frame(input logic [7:0] exp);
        logic [7:0] d;
        wait_line_low();
        repeat (bit_clks / 2) next_edge();
        check_value("txd start", 32'(txd), 32'h0);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) next_edge();
            d[i] = txd;
        end
        check_value("txd data", 32'(d), 32'(exp));
        if (has_parity(parity_sel)) begin
            repeat (bit_clks) next_edge();
            check_value("txd parity", 32'(txd), 32'(parity_of(exp, parity_sel)));
        end
        repeat (bit_clks) next_edge();
        check_value("txd stop", 32'(txd), 32'h1);
    endtask

    task automatic measure_start(output int len);
        wait_line_low();
        len = 0;
        while (txd === 1'b0) begin
            if (len > 4 * bit_clks) timeout_fail("the end of the start bit");
            len++;
            next_edge();
        end
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (tx_busy !== 1'b0) begin
            if (n == 4 * bit_clks) timeout_fail("tx_busy to fall");
            n++;
            next_edge();
        end
        next_edge();                                // Let the counters settle
    endtask

    task automatic read_entry(input logic [7:0] exp, input logic exp_err);
        int n;
        n = 0;
        while (rx_ready !== 1'b1) begin
            if (n == 4 * bit_clks) timeout_fail("rx_ready");
            n++;
            next_edge();
        end
        check_value("rx_data", 32'(rx_data), 32'(exp));
        check_value("rx_error", 32'(rx_error), 32'(exp_err));
        rx_rd = 1'b1;
        next_edge();
        rx_rd = 1'b0;
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic test_reset();
        check_value("txd", 32'(txd), 32'h1);
        check_value("tx_busy", 32'(tx_busy), 32'h0);
        check_value("tx_done", 32'(tx_done), 32'h0);
        check_value("tx_full", 32'(tx_full), 32'h0);
        check_value("rx_ready", 32'(rx_ready), 32'h0);
        check_value("rx_error", 32'(rx_error), 32'h0);
        check_value("rx_overrun", 32'(rx_overrun), 32'h0);
    endtask

    task automatic test_tx_fast();
        logic [7:0] q [$];
        int         first;
        for (int m = 0; m < 4; m++) begin
            parity_sel = 2'(m);                     // Reserved mode sends no parity
            q.delete();
            for (int i = 0; i < 6; i++) q.push_back(next_byte());
            first = done_cnt;
            fork
                foreach (q[i]) push_byte(q[i]);
                foreach (q[i]) expect_frame(q[i]);
            join
            wait_tx_idle();
            check_value("tx_done pulses", 32'(done_cnt - first), 32'd6);
        end
    endtask

    task automatic test_rx();
        logic [7:0] b;
        for (int m = 0; m < 3; m++) begin
            parity_sel = 2'(m);
            for (int i = 0; i < 4; i++) begin
                b = next_byte();
                send_frame(b, 1'b0, 1'b1);
                read_entry(b, 1'b0);
                check_value("rx_ready", 32'(rx_ready), 32'h0);
            end
        end
    endtask

    task automatic test_errors();
        logic [7:0] b;
        parity_sel = uart_pkg::PARITY_EVEN;
        b = next_byte();
        send_frame(b, 1'b1, 1'b1);                  // Parity flipped
        read_entry(b, 1'b1);
        parity_sel = uart_pkg::PARITY_NONE;
        b = next_byte();
        send_frame(b, 1'b0, 1'b0);                  // Stop bit low
        read_entry(b, 1'b1);
        b = next_byte();
        send_frame(b, 1'b0, 1'b1);
        read_entry(b, 1'b0);
    endtask

    task automatic test_overrun();
        logic [7:0] sent [$];
        int         first;
        first = ovr_cnt;
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            sent.push_back(next_byte());
            send_frame(sent[i], 1'b0, 1'b1);        // Last one finds the FIFO full
        end
        check_value("rx_overrun pulses", 32'(ovr_cnt - first), 32'd1);
        for (int i = 0; i < FIFO_DEPTH; i++) read_entry(sent[i], 1'b0);
        check_value("rx_ready", 32'(rx_ready), 32'h0);
    endtask

    task automatic test_slow();
        logic [7:0] b;
        int         len;
        baud_sel = uart_pkg::BAUD_9600;
        bit_clks = 16 * DIV_SLOW;
        b = next_byte() | 8'h01;                    // Bit 0 high so the start bit stands alone
        fork
            push_byte(b);
            measure_start(len);
            expect_frame(b);
        join
        // One tick either side counts as exact
        if (len >= bit_clks - DIV_SLOW && len <= bit_clks + DIV_SLOW) len = bit_clks;
        check_value("start bit length", 32'(len), 32'(bit_clks));
        wait_tx_idle();
    endtask

    initial begin
        rst_n      = 1'b0;
        tx_data    = 8'h00;
        tx_en      = 1'b0;
        rxd        = 1'b1;
        rx_rd      = 1'b0;
        parity_sel = uart_pkg::PARITY_NONE;
        baud_sel   = uart_pkg::BAUD_115200;
        seed       = 32'hc2da_418a;
        bit_clks   = 16 * DIV_FAST;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_edge();
        test_reset();
        test_tx_fast();
        test_rx();
        test_errors();
        test_overrun();
        test_slow();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/uart_pkg.sv
design/uart_fifo_if.sv
design/uart_baud_gen.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_core.sv
test/uart_core_props.sv
test/uart_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= uart_core_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
